//--- rtl/id_pkg.sv
package id_pkg;

    localparam int xlen      = 32;
    localparam int reg_idx_w = 5;

    // bl writes its return address here
    localparam logic [reg_idx_w-1:0] link_reg = 5'd1;

    typedef enum logic [5:0] {
        INST_ILLEGAL,
        INST_ADD, INST_SUB, INST_SLT, INST_SLTU,
        INST_AND, INST_OR, INST_NOR, INST_XOR,
        INST_SLL, INST_SRL, INST_SRA,
        INST_ADDI, INST_SLTI, INST_SLTUI,
        INST_ANDI, INST_ORI, INST_XORI,
        INST_SLLI, INST_SRLI, INST_SRAI,
        INST_LU12I, INST_PCADDU12I,
        INST_B, INST_BL, INST_JIRL,
        INST_BEQ, INST_BNE, INST_BLT, INST_BGE, INST_BLTU, INST_BGEU,
        INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
        INST_ST_B, INST_ST_H, INST_ST_W,
        INST_SYSCALL, INST_BREAK
    } inst_kind_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_SLTU,
        ALU_AND, ALU_OR, ALU_NOR, ALU_XOR,
        ALU_SLL, ALU_SRL, ALU_SRA,
        ALU_LUI
    } alu_op_e;

    typedef enum logic [3:0] {
        BR_NONE, BR_JIRL, BR_JUMP,
        BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU
    } branch_op_e;

    typedef enum logic [1:0] {
        MEM_BYTE, MEM_HALF, MEM_WORD
    } mem_size_e;

    typedef enum logic [1:0] {
        SRC_REG, SRC_IMM, SRC_PC
    } src_sel_e;

    typedef enum logic [2:0] {
        IMM_NONE, IMM_SI12, IMM_UI12, IMM_UI5, IMM_SI16, IMM_SI26, IMM_HI20
    } imm_fmt_e;

    typedef enum logic [1:0] {
        EXCP_NONE, EXCP_SYSCALL, EXCP_BREAK, EXCP_INE
    } excp_code_e;

endpackage

//--- rtl/id_ctrl_if.sv
`timescale 1ns/1ps

interface id_ctrl_if;
    import id_pkg::*;

    alu_op_e               alu_op;
    branch_op_e            branch_op;
    logic                  mem_en;
    logic                  mem_store;
    mem_size_e             mem_size;
    logic                  mem_unsigned;
    src_sel_e              src1_sel;
    src_sel_e              src2_sel;
    logic                  wreg_en;
    logic [reg_idx_w-1:0]  wreg_index;
    excp_code_e            excp_code;
    logic [xlen-1:0]       imm;

    modport ctrl_src (output alu_op, branch_op, mem_en, mem_store, mem_size, mem_unsigned,
                      src1_sel, src2_sel, wreg_en, wreg_index, excp_code);
    modport imm_src (output imm);
    modport sink (input alu_op, branch_op, mem_en, mem_store, mem_size, mem_unsigned,
                  src1_sel, src2_sel, wreg_en, wreg_index, excp_code, imm);
endinterface

//--- rtl/inst_field_decoder.sv
`timescale 1ns/1ps

module inst_field_decoder (
    input  logic [id_pkg::xlen-1:0] inst,
    output id_pkg::inst_kind_e      kind
);
    import id_pkg::*;

    logic [5:0] op_31_26;
    logic [3:0] op_25_22;
    logic [1:0] op_21_20;
    logic [4:0] op_19_15;
    logic       guard_25;

    assign op_31_26 = inst[31:26];
    assign op_25_22 = inst[25:22];
    assign op_21_20 = inst[21:20];
    assign op_19_15 = inst[19:15];
    // lu12i and pcaddu12i need bit 25 clear
    assign guard_25 = inst[25];

    always_comb begin
        kind = INST_ILLEGAL;
        case (op_31_26)
            6'h00: begin
                case (op_25_22)
                    4'h0: begin
                        // three-register ops
                        if (op_21_20 == 2'h1) begin
                            case (op_19_15)
                                5'h00: kind = INST_ADD;
                                5'h02: kind = INST_SUB;
                                5'h04: kind = INST_SLT;
                                5'h05: kind = INST_SLTU;
                                5'h08: kind = INST_NOR;
                                5'h09: kind = INST_AND;
                                5'h0a: kind = INST_OR;
                                5'h0b: kind = INST_XOR;
                                5'h0e: kind = INST_SLL;
                                5'h0f: kind = INST_SRL;
                                5'h10: kind = INST_SRA;
                                default: kind = INST_ILLEGAL;
                            endcase
                        end else if (op_21_20 == 2'h2) begin
                            case (op_19_15)
                                5'h14: kind = INST_BREAK;
                                5'h16: kind = INST_SYSCALL;
                                default: kind = INST_ILLEGAL;
                            endcase
                        end
                    end
                    4'h1: begin
                        // shifts by ui5
                        if (op_21_20 == 2'h0) begin
                            case (op_19_15)
                                5'h01: kind = INST_SLLI;
                                5'h09: kind = INST_SRLI;
                                5'h11: kind = INST_SRAI;
                                default: kind = INST_ILLEGAL;
                            endcase
                        end
                    end
                    4'h8: kind = INST_SLTI;
                    4'h9: kind = INST_SLTUI;
                    4'ha: kind = INST_ADDI;
                    4'hd: kind = INST_ANDI;
                    4'he: kind = INST_ORI;
                    4'hf: kind = INST_XORI;
                    default: kind = INST_ILLEGAL;
                endcase
            end
            6'h05: begin
                if (!guard_25) begin
                    kind = INST_LU12I;
                end
            end
            6'h07: begin
                if (!guard_25) begin
                    kind = INST_PCADDU12I;
                end
            end
            6'h0a: begin
                // loads and stores, 25:22 picks size and direction
                case (op_25_22)
                    4'h0: kind = INST_LD_B;
                    4'h1: kind = INST_LD_H;
                    4'h2: kind = INST_LD_W;
                    4'h4: kind = INST_ST_B;
                    4'h5: kind = INST_ST_H;
                    4'h6: kind = INST_ST_W;
                    4'h8: kind = INST_LD_BU;
                    4'h9: kind = INST_LD_HU;
                    default: kind = INST_ILLEGAL;
                endcase
            end
            6'h13: kind = INST_JIRL;
            6'h14: kind = INST_B;
            6'h15: kind = INST_BL;
            6'h16: kind = INST_BEQ;
            6'h17: kind = INST_BNE;
            6'h18: kind = INST_BLT;
            6'h19: kind = INST_BGE;
            6'h1a: kind = INST_BLTU;
            6'h1b: kind = INST_BGEU;
            default: kind = INST_ILLEGAL;
        endcase
    end

endmodule

//--- rtl/ctrl_gen.sv
`timescale 1ns/1ps

module ctrl_gen (
    input  id_pkg::inst_kind_e       kind,
    input  logic [id_pkg::xlen-1:0] inst,
    id_ctrl_if.ctrl_src              ctrl,
    output id_pkg::imm_fmt_e         imm_fmt,
    output logic                     reg2_from_rd
);
    import id_pkg::*;

    logic pc_src;
    logic no_write;

    // address, link and pc-relative math all go through add
    always_comb begin
        case (kind)
            INST_SUB:              ctrl.alu_op = ALU_SUB;
            INST_SLT, INST_SLTI:   ctrl.alu_op = ALU_SLT;
            INST_SLTU, INST_SLTUI: ctrl.alu_op = ALU_SLTU;
            INST_AND, INST_ANDI:   ctrl.alu_op = ALU_AND;
            INST_OR, INST_ORI:     ctrl.alu_op = ALU_OR;
            INST_NOR:              ctrl.alu_op = ALU_NOR;
            INST_XOR, INST_XORI:   ctrl.alu_op = ALU_XOR;
            INST_SLL, INST_SLLI:   ctrl.alu_op = ALU_SLL;
            INST_SRL, INST_SRLI:   ctrl.alu_op = ALU_SRL;
            INST_SRA, INST_SRAI:   ctrl.alu_op = ALU_SRA;
            INST_LU12I:            ctrl.alu_op = ALU_LUI;
            default:               ctrl.alu_op = ALU_ADD;
        endcase
    end

    always_comb begin
        case (kind)
            INST_JIRL:       ctrl.branch_op = BR_JIRL;
            INST_B, INST_BL: ctrl.branch_op = BR_JUMP;
            INST_BEQ:        ctrl.branch_op = BR_BEQ;
            INST_BNE:        ctrl.branch_op = BR_BNE;
            INST_BLT:        ctrl.branch_op = BR_BLT;
            INST_BGE:        ctrl.branch_op = BR_BGE;
            INST_BLTU:       ctrl.branch_op = BR_BLTU;
            INST_BGEU:       ctrl.branch_op = BR_BGEU;
            default:         ctrl.branch_op = BR_NONE;
        endcase
    end

    assign ctrl.mem_en = kind inside {INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
                                      INST_ST_B, INST_ST_H, INST_ST_W};
    assign ctrl.mem_store    = kind inside {INST_ST_B, INST_ST_H, INST_ST_W};
    assign ctrl.mem_unsigned = kind inside {INST_LD_BU, INST_LD_HU};

    always_comb begin
        case (kind)
            INST_LD_H, INST_LD_HU, INST_ST_H: ctrl.mem_size = MEM_HALF;
            INST_LD_W, INST_ST_W:             ctrl.mem_size = MEM_WORD;
            default:                          ctrl.mem_size = MEM_BYTE;
        endcase
    end

    always_comb begin
        case (kind)
            INST_ADDI, INST_SLTI, INST_SLTUI,
            INST_LD_B, INST_LD_H, INST_LD_W, INST_LD_BU, INST_LD_HU,
            INST_ST_B, INST_ST_H, INST_ST_W:            imm_fmt = IMM_SI12;
            INST_ANDI, INST_ORI, INST_XORI:             imm_fmt = IMM_UI12;
            INST_SLLI, INST_SRLI, INST_SRAI:            imm_fmt = IMM_UI5;
            INST_JIRL, INST_BEQ, INST_BNE, INST_BLT,
            INST_BGE, INST_BLTU, INST_BGEU:             imm_fmt = IMM_SI16;
            INST_B, INST_BL:                            imm_fmt = IMM_SI26;
            INST_LU12I, INST_PCADDU12I:                 imm_fmt = IMM_HI20;
            default:                                    imm_fmt = IMM_NONE;
        endcase
    end

    // jirl targets rj plus offset, so its first source stays the register
    assign pc_src = kind inside {INST_B, INST_BL, INST_BEQ, INST_BNE, INST_BLT, INST_BGE,
                                 INST_BLTU, INST_BGEU, INST_PCADDU12I};
    assign ctrl.src1_sel = pc_src ? SRC_PC : SRC_REG;
    assign ctrl.src2_sel = (imm_fmt != IMM_NONE) ? SRC_IMM : SRC_REG;

    // stores and compares read rd as second operand
    assign reg2_from_rd = kind inside {INST_ST_B, INST_ST_H, INST_ST_W, INST_BEQ, INST_BNE,
                                       INST_BLT, INST_BGE, INST_BLTU, INST_BGEU};

    assign no_write = reg2_from_rd
                    | (kind inside {INST_B, INST_SYSCALL, INST_BREAK, INST_ILLEGAL});
    assign ctrl.wreg_en    = !no_write;
    assign ctrl.wreg_index = (kind == INST_BL) ? link_reg : inst[reg_idx_w-1:0];

    always_comb begin
        case (kind)
            INST_SYSCALL: ctrl.excp_code = EXCP_SYSCALL;
            INST_BREAK:   ctrl.excp_code = EXCP_BREAK;
            INST_ILLEGAL: ctrl.excp_code = EXCP_INE;
            default:      ctrl.excp_code = EXCP_NONE;
        endcase
    end

endmodule

//--- rtl/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
    input  logic [id_pkg::xlen-1:0] inst,
    input  id_pkg::imm_fmt_e         imm_fmt,
    id_ctrl_if.imm_src               ctrl
);
    import id_pkg::*;

    logic [11:0] i12;
    logic [4:0]  i5;
    logic [15:0] i16;
    logic [25:0] i26;
    logic [19:0] i20;

    assign i12 = inst[21:10];
    assign i5  = inst[14:10];
    assign i16 = inst[25:10];
    // low offset bits sit above the high ones in the word
    assign i26 = {inst[9:0], inst[25:10]};
    assign i20 = inst[24:5];

    always_comb begin
        case (imm_fmt)
            IMM_SI12: ctrl.imm = {{20{i12[11]}}, i12};
            IMM_UI12: ctrl.imm = {20'h0, i12};
            IMM_UI5:  ctrl.imm = {27'h0, i5};
            // branch offsets count words
            IMM_SI16: ctrl.imm = {{14{i16[15]}}, i16, 2'b00};
            IMM_SI26: ctrl.imm = {{4{i26[25]}}, i26, 2'b00};
            IMM_HI20: ctrl.imm = {i20, 12'h0};
            default:  ctrl.imm = '0;
        endcase
    end

endmodule

//--- rtl/id_stage_reg.sv
`timescale 1ns/1ps

module id_stage_reg (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          if_valid,
    input  logic                          ex_ready,
    input  logic [id_pkg::xlen-1:0]       pc,
    input  logic [id_pkg::xlen-1:0]       inst,
    input  logic [id_pkg::xlen-1:0]       reg_data1,
    input  logic [id_pkg::xlen-1:0]       reg_data2,
    id_ctrl_if.sink                       ctrl,
    output logic                          ex_valid,
    output id_pkg::alu_op_e               ex_alu_op,
    output id_pkg::branch_op_e            ex_branch_op,
    output logic                          ex_mem_en,
    output logic                          ex_mem_store,
    output id_pkg::mem_size_e             ex_mem_size,
    output logic                          ex_mem_unsigned,
    output id_pkg::src_sel_e              ex_src1_sel,
    output id_pkg::src_sel_e              ex_src2_sel,
    output logic                          ex_wreg_en,
    output logic [id_pkg::reg_idx_w-1:0]  ex_wreg_index,
    output id_pkg::excp_code_e            ex_excp_code,
    output logic [id_pkg::xlen-1:0]       ex_imm,
    output logic [id_pkg::xlen-1:0]       ex_pc,
    output logic [id_pkg::xlen-1:0]       ex_inst,
    output logic [id_pkg::xlen-1:0]       ex_src1,
    output logic [id_pkg::xlen-1:0]       ex_src2
);
    import id_pkg::*;

    logic if_fire;

    // fetch side is ready whenever execute is
    assign if_fire = if_valid & ex_ready;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_valid <= 1'b0;
        end else if (flush) begin
            ex_valid <= 1'b0;
        end else if (ex_ready) begin
            // drain and refill in one cycle, no bubble
            ex_valid <= if_valid;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ex_alu_op       <= ALU_ADD;
            ex_branch_op    <= BR_NONE;
            ex_mem_en       <= 1'b0;
            ex_mem_store    <= 1'b0;
            ex_mem_size     <= MEM_BYTE;
            ex_mem_unsigned <= 1'b0;
            ex_src1_sel     <= SRC_REG;
            ex_src2_sel     <= SRC_REG;
            ex_wreg_en      <= 1'b0;
            ex_wreg_index   <= '0;
            ex_excp_code    <= EXCP_NONE;
            ex_imm          <= '0;
            ex_pc           <= '0;
            ex_inst         <= '0;
            ex_src1         <= '0;
            ex_src2         <= '0;
        end else if (if_fire) begin
            ex_alu_op       <= ctrl.alu_op;
            ex_branch_op    <= ctrl.branch_op;
            ex_mem_en       <= ctrl.mem_en;
            ex_mem_store    <= ctrl.mem_store;
            ex_mem_size     <= ctrl.mem_size;
            ex_mem_unsigned <= ctrl.mem_unsigned;
            ex_src1_sel     <= ctrl.src1_sel;
            ex_src2_sel     <= ctrl.src2_sel;
            ex_wreg_en      <= ctrl.wreg_en;
            ex_wreg_index   <= ctrl.wreg_index;
            ex_excp_code    <= ctrl.excp_code;
            ex_imm          <= ctrl.imm;
            ex_pc           <= pc;
            ex_inst         <= inst;
            ex_src1         <= reg_data1;
            ex_src2         <= reg_data2;
        end
    end

endmodule

//--- rtl/id_stage.sv
`timescale 1ns/1ps

module id_stage (
    input  logic                          clk,
    input  logic                          arst_n,
    input  logic                          flush,
    input  logic                          if_valid,
    output logic                          if_ready,
    input  logic [id_pkg::xlen-1:0]       if_inst,
    input  logic [id_pkg::xlen-1:0]       if_pc,
    output logic [id_pkg::reg_idx_w-1:0]  reg_index1,
    output logic [id_pkg::reg_idx_w-1:0]  reg_index2,
    input  logic [id_pkg::xlen-1:0]       reg_data1,
    input  logic [id_pkg::xlen-1:0]       reg_data2,
    output logic                          ex_valid,
    input  logic                          ex_ready,
    output logic [id_pkg::xlen-1:0]       ex_pc,
    output logic [id_pkg::xlen-1:0]       ex_inst,
    output id_pkg::alu_op_e               ex_alu_op,
    output id_pkg::branch_op_e            ex_branch_op,
    output logic                          ex_mem_en,
    output logic                          ex_mem_store,
    output id_pkg::mem_size_e             ex_mem_size,
    output logic                          ex_mem_unsigned,
    output id_pkg::src_sel_e              ex_src1_sel,
    output id_pkg::src_sel_e              ex_src2_sel,
    output logic                          ex_wreg_en,
    output logic [id_pkg::reg_idx_w-1:0]  ex_wreg_index,
    output logic [id_pkg::xlen-1:0]       ex_src1,
    output logic [id_pkg::xlen-1:0]       ex_src2,
    output logic [id_pkg::xlen-1:0]       ex_imm,
    output id_pkg::excp_code_e            ex_excp_code
);
    import id_pkg::*;

    inst_kind_e kind;
    imm_fmt_e   imm_fmt;
    logic       reg2_from_rd;

    id_ctrl_if ctrl_if ();

    assign if_ready = ex_ready;

    // register file read indices, rj and then rd or rk
    assign reg_index1 = if_inst[9:5];
    assign reg_index2 = reg2_from_rd ? if_inst[4:0] : if_inst[14:10];

    inst_field_decoder u_field_dec (
        .inst (if_inst),
        .kind (kind)
    );

    ctrl_gen u_ctrl_gen (
        .kind         (kind),
        .inst         (if_inst),
        .ctrl         (ctrl_if.ctrl_src),
        .imm_fmt      (imm_fmt),
        .reg2_from_rd (reg2_from_rd)
    );

    imm_gen u_imm_gen (
        .inst    (if_inst),
        .imm_fmt (imm_fmt),
        .ctrl    (ctrl_if.imm_src)
    );

    id_stage_reg u_stage_reg (
        .clk             (clk),
        .arst_n          (arst_n),
        .flush           (flush),
        .if_valid        (if_valid),
        .ex_ready        (ex_ready),
        .pc              (if_pc),
        .inst            (if_inst),
        .reg_data1       (reg_data1),
        .reg_data2       (reg_data2),
        .ctrl            (ctrl_if.sink),
        .ex_valid        (ex_valid),
        .ex_alu_op       (ex_alu_op),
        .ex_branch_op    (ex_branch_op),
        .ex_mem_en       (ex_mem_en),
        .ex_mem_store    (ex_mem_store),
        .ex_mem_size     (ex_mem_size),
        .ex_mem_unsigned (ex_mem_unsigned),
        .ex_src1_sel     (ex_src1_sel),
        .ex_src2_sel     (ex_src2_sel),
        .ex_wreg_en      (ex_wreg_en),
        .ex_wreg_index   (ex_wreg_index),
        .ex_excp_code    (ex_excp_code),
        .ex_imm          (ex_imm),
        .ex_pc           (ex_pc),
        .ex_inst         (ex_inst),
        .ex_src1         (ex_src1),
        .ex_src2         (ex_src2)
    );

endmodule

//--- testbench/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk,
    output logic arst_n
);

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // reset held for the first ten rising edges
    initial begin
        arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
    end

endmodule

//--- testbench/id_stage_properties.sv
`timescale 1ns/1ps

module id_stage_properties (
    input logic clk, arst_n, flush, if_valid, if_ready, ex_valid, ex_ready,
    input logic ex_mem_en, ex_mem_store, ex_mem_unsigned, ex_wreg_en,
    input logic [id_pkg::xlen-1:0] if_inst, if_pc, reg_data1, reg_data2,
    input logic [id_pkg::xlen-1:0] ex_pc, ex_inst, ex_src1, ex_src2, ex_imm,
    input logic [id_pkg::reg_idx_w-1:0] reg_index1, reg_index2, ex_wreg_index,
    input id_pkg::alu_op_e ex_alu_op,
    input id_pkg::branch_op_e ex_branch_op,
    input id_pkg::mem_size_e ex_mem_size,
    input id_pkg::src_sel_e ex_src1_sel, ex_src2_sel,
    input id_pkg::excp_code_e ex_excp_code
);
    import id_pkg::*;

    int fail_count = 0;

    logic [5:0]      op6;
    logic [9:0]      op10;
    logic [xlen-1:0] sx12, zx12, sx16, sx26;
    logic            arith_imm, shift_imm, cond_br, mem_op, store_op, known_op, fetch_rd2;
    logic [184:0]    ex_bundle;
    branch_op_e      cond_br_op;

    task automatic record_failure(input string what);
        $error("FAIL at %0t: %s", $time, what);
        fail_count++;
    endtask

    // expected fields, rebuilt from the captured word
    assign op6  = ex_inst[31:26];
    assign op10 = ex_inst[31:22];
    assign sx12 = {{20{ex_inst[21]}}, ex_inst[21:10]};
    assign zx12 = {20'h0, ex_inst[21:10]};
    // branch offsets count words
    assign sx16 = {{14{ex_inst[25]}}, ex_inst[25:10], 2'b00};
    assign sx26 = {{4{ex_inst[9]}}, ex_inst[9:0], ex_inst[25:10], 2'b00};

    assign arith_imm = op10 inside {10'h008, 10'h009, 10'h00a, 10'h00d, 10'h00e, 10'h00f};
    assign shift_imm = ex_inst[31:15] inside {17'h00081, 17'h00089, 17'h00091};
    assign cond_br   = op6 inside {[6'h16:6'h1b]};
    assign mem_op    = (op6 == 6'h0a)
                     && (ex_inst[25:22] inside {[4'h0:4'h2], [4'h4:4'h6], 4'h8, 4'h9});
    assign store_op  = (op6 == 6'h0a) && (ex_inst[25:22] inside {[4'h4:4'h6]});
    assign known_op  = op6 inside {6'h00, 6'h05, 6'h07, 6'h0a, [6'h13:6'h1b]};
    // stores and compares on the fetch side read rd
    assign fetch_rd2 = (if_inst[31:26] inside {[6'h16:6'h1b]})
                     || (if_inst[31:26] == 6'h0a && if_inst[25:22] inside {[4'h4:4'h6]});

    // compare kind from the major opcode
    always_comb begin
        case (op6)
            6'h16:   cond_br_op = BR_BEQ;
            6'h17:   cond_br_op = BR_BNE;
            6'h18:   cond_br_op = BR_BLT;
            6'h19:   cond_br_op = BR_BGE;
            6'h1a:   cond_br_op = BR_BLTU;
            6'h1b:   cond_br_op = BR_BGEU;
            default: cond_br_op = BR_NONE;
        endcase
    end

    assign ex_bundle = {ex_pc, ex_inst, ex_src1, ex_src2, ex_imm, ex_alu_op, ex_branch_op,
                        ex_mem_en, ex_mem_store, ex_mem_size, ex_mem_unsigned, ex_src1_sel,
                        ex_src2_sel, ex_wreg_en, ex_wreg_index, ex_excp_code};

    ap_reset: assert property (@(posedge clk) $rose(arst_n) |-> !ex_valid && !ex_wreg_en)
        else record_failure("outputs not cleared after reset");

    ap_ready: assert property (@(posedge clk) disable iff (!arst_n) if_ready == ex_ready)
        else record_failure("if_ready differs from ex_ready");

    ap_capture: assert property (@(posedge clk) disable iff (!arst_n)
        if_valid && ex_ready && !flush |=> ex_valid && ex_pc == $past(if_pc)
            && ex_inst == $past(if_inst) && ex_src1 == $past(reg_data1)
            && ex_src2 == $past(reg_data2))
        else record_failure("fetch transfer not captured one cycle later");

    ap_hold: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && !ex_ready && !flush |=> ex_valid && $stable(ex_bundle))
        else record_failure("slot changed while execute stalled");

    ap_flush: assert property (@(posedge clk) disable iff (!arst_n) flush |=> !ex_valid)
        else record_failure("slot still valid after flush");

    ap_alu: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid |-> (op10 != 10'h00a || ex_alu_op == ALU_ADD)
            && (op10 != 10'h00e || ex_alu_op == ALU_OR)
            && (op6 != 6'h05 || ex_inst[25] || ex_alu_op == ALU_LUI)
            && (ex_inst[31:15] != 17'h00081 || ex_alu_op == ALU_SLL))
        else record_failure("wrong alu operation");

    ap_arith_imm: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && arith_imm |-> ex_src2_sel == SRC_IMM && ex_wreg_en
            && ex_wreg_index == ex_inst[4:0]
            && ex_imm == ((op10 inside {10'h00d, 10'h00e, 10'h00f}) ? zx12 : sx12))
        else record_failure("immediate arithmetic decode");

    ap_shift_imm: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && shift_imm |-> ex_src2_sel == SRC_IMM && ex_wreg_en
            && ex_wreg_index == ex_inst[4:0] && ex_imm == {27'h0, ex_inst[14:10]})
        else record_failure("immediate shift decode");

    // b and bl differ only in bit 26
    ap_jump: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && (op6 inside {6'h14, 6'h15}) |-> ex_imm == sx26 && ex_src1_sel == SRC_PC
            && ex_branch_op == BR_JUMP
            && ex_wreg_en == ex_inst[26] && (!ex_inst[26] || ex_wreg_index == link_reg))
        else record_failure("b or bl decode");

    ap_cond_br: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && cond_br |-> !ex_wreg_en && ex_imm == sx16 && ex_src1_sel == SRC_PC
            && ex_branch_op == cond_br_op)
        else record_failure("conditional branch decode");

    ap_jirl: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && op6 == 6'h13 |-> ex_wreg_en && ex_wreg_index == ex_inst[4:0]
            && ex_imm == sx16 && ex_branch_op == BR_JIRL)
        else record_failure("jirl decode");

    ap_index: assert property (@(posedge clk) disable iff (!arst_n)
        reg_index1 == if_inst[9:5]
            && reg_index2 == (fetch_rd2 ? if_inst[4:0] : if_inst[14:10]))
        else record_failure("register read index");

    ap_mem: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && mem_op |-> ex_mem_en && ex_alu_op == ALU_ADD && ex_imm == sx12
            && ex_mem_store == store_op && (!store_op || !ex_wreg_en))
        else record_failure("load or store decode");

    ap_unsigned: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid && mem_op && ex_inst[25:23] == 3'b100 |-> ex_mem_unsigned
            && ex_mem_size == (ex_inst[22] ? MEM_HALF : MEM_BYTE))
        else record_failure("unsigned load decode");

    ap_excp: assert property (@(posedge clk) disable iff (!arst_n)
        ex_valid |-> (known_op || (ex_excp_code == EXCP_INE && !ex_wreg_en))
            && (ex_inst[31:15] != 17'h00056 || ex_excp_code == EXCP_SYSCALL)
            && (ex_inst[31:15] != 17'h00054 || ex_excp_code == EXCP_BREAK))
        else record_failure("exception code");

endmodule

bind id_stage id_stage_properties props (.*);

//--- testbench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb;
    import id_pkg::*;

    logic clk, arst_n, flush, if_valid, if_ready, ex_valid, ex_ready;
    logic ex_mem_en, ex_mem_store, ex_mem_unsigned, ex_wreg_en;
    logic [xlen-1:0] if_inst, if_pc, reg_data1, reg_data2;
    logic [xlen-1:0] ex_pc, ex_inst, ex_src1, ex_src2, ex_imm;
    logic [reg_idx_w-1:0] reg_index1, reg_index2, ex_wreg_index;
    alu_op_e    ex_alu_op;
    branch_op_e ex_branch_op;
    mem_size_e  ex_mem_size;
    src_sel_e   ex_src1_sel, ex_src2_sel;
    excp_code_e ex_excp_code;

    logic [31:0] rng = 32'h18d1;
    int timeouts = 0;
    int tests = 0;

    // opcode bits in the upper half, mask of fixed bits in the lower
    logic [63:0] op_tab [0:31] = '{
        // addi slti sltui andi ori xori
        64'h02800000_ffc00000, 64'h02000000_ffc00000, 64'h02400000_ffc00000,
        64'h03400000_ffc00000, 64'h03800000_ffc00000, 64'h03c00000_ffc00000,
        // slli srli srai lu12i pcaddu12i
        64'h00408000_ffff8000, 64'h00448000_ffff8000, 64'h00488000_ffff8000,
        64'h14000000_fe000000, 64'h1c000000_fe000000,
        // b bl jirl, then beq through bgeu
        64'h50000000_fc000000, 64'h54000000_fc000000, 64'h4c000000_fc000000,
        64'h58000000_fc000000, 64'h5c000000_fc000000, 64'h60000000_fc000000,
        64'h64000000_fc000000, 64'h68000000_fc000000, 64'h6c000000_fc000000,
        // ld.b ld.h ld.w ld.bu ld.hu st.b st.h st.w
        64'h28000000_ffc00000, 64'h28400000_ffc00000, 64'h28800000_ffc00000,
        64'h2a000000_ffc00000, 64'h2a400000_ffc00000, 64'h29000000_ffc00000,
        64'h29400000_ffc00000, 64'h29800000_ffc00000,
        // unknown opcode, syscall, break, add
        64'hfc000000_fc000000, 64'h002b0000_ffff8000, 64'h002a0000_ffff8000,
        64'h00100000_ffff8000
    };

    tb_clock_gen clk_gen (.*);

    id_stage uut (.*);

    function automatic logic [31:0] next_rand();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    function automatic logic rand_bit();
        logic [31:0] r;
        r = next_rand();
        return r[7];
    endfunction

    // register and immediate fields come from the generator
    function automatic logic [31:0] make_inst(input int idx);
        return op_tab[idx][63:32] | (next_rand() & ~op_tab[idx][31:0]);
    endfunction

    task automatic send_inst(input int idx, input bit toggle, input bit with_flush);
        int waited;
        @(posedge clk);
        if_valid  <= 1'b1;
        if_inst   <= make_inst(idx);
        if_pc     <= next_rand() & 32'hffff_fffc;
        reg_data1 <= next_rand();
        reg_data2 <= next_rand();
        flush     <= with_flush;
        ex_ready  <= toggle ? rand_bit() : 1'b1;
        waited = 0;
        do begin
            @(posedge clk);
            waited++;
            if (!ex_ready) begin
                ex_ready <= rand_bit();
            end
        end while (!ex_ready && waited < 64);
        if (!ex_ready) begin
            timeouts++;
            $display("timeout: table entry %0d was never accepted by the stage", idx);
        end
        if_valid <= 1'b0;
        flush    <= 1'b0;
        // execute may stall while the slot is still full
        if (toggle) begin
            ex_ready <= rand_bit();
        end
    endtask

    task automatic run_tests(input string name, input int first, input int last,
                             input int reps, input bit toggle);
        for (int r = 0; r < reps; r++) begin
            for (int i = first; i <= last; i++) begin
                send_inst(i, toggle, 1'b0);
            end
        end
        ex_ready <= 1'b1;
        tests++;
        $display("test %s done at %0t, assertion failures so far %0d",
                 name, $time, uut.props.fail_count);
    endtask

    initial begin
        int waited;
        flush     = 1'b0;
        if_valid  = 1'b0;
        ex_ready  = 1'b1;
        if_inst   = '0;
        if_pc     = '0;
        reg_data1 = '0;
        reg_data2 = '0;
        waited = 0;
        while (!arst_n && waited < 40) begin
            @(posedge clk);
            waited++;
        end
        if (!arst_n) begin
            timeouts++;
            $display("timeout: reset was never released");
        end
        tests++;
        $display("test reset done at %0t", $time);

        run_tests("handshake", 0, 31, 2, 1'b1);
        run_tests("arith", 0, 10, 3, 1'b0);
        run_tests("branch", 11, 19, 3, 1'b0);
        run_tests("memory", 20, 27, 3, 1'b0);
        run_tests("exception", 28, 30, 3, 1'b0);

        // flush a full slot while execute stalls, then flush during a transfer
        send_inst(31, 1'b0, 1'b0);
        ex_ready <= 1'b0;
        flush    <= 1'b1;
        @(posedge clk);
        flush    <= 1'b0;
        ex_ready <= 1'b1;
        send_inst(0, 1'b0, 1'b1);
        repeat (2) @(posedge clk);
        tests++;
        $display("test flush done at %0t, assertion failures so far %0d",
                 $time, uut.props.fail_count);

        $display("%0d tests, %0d assertion failures, %0d timeouts",
                 tests, uut.props.fail_count, timeouts);
        if (uut.props.fail_count == 0 && timeouts == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- id_stage.f
rtl/id_pkg.sv
rtl/id_ctrl_if.sv
rtl/inst_field_decoder.sv
rtl/ctrl_gen.sv
rtl/imm_gen.sv
rtl/id_stage_reg.sv
rtl/id_stage.sv
testbench/tb_clock_gen.sv
testbench/id_stage_properties.sv
testbench/id_stage_tb.sv
